// File: hw/rv_isa_pkg.sv
//////////////////////////////////////////////////
// RV64I opcodes, funct3 codes, machine CSR
// addresses and the instruction word views.
//////////////////////////////////////////////////
`default_nettype none

package rv_isa_pkg;

  localparam int XLEN = 64;

  // Major opcodes.
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // ALU funct3.
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // Branch funct3.
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // CSR funct3. The low two bits give the access kind.
  localparam logic [2:0] F3_CSRRW  = 3'b001;
  localparam logic [2:0] F3_CSRRS  = 3'b010;
  localparam logic [2:0] F3_CSRRC  = 3'b011;
  localparam logic [2:0] F3_CSRRWI = 3'b101;
  localparam logic [2:0] F3_CSRRSI = 3'b110;
  localparam logic [2:0] F3_CSRRCI = 3'b111;

  localparam logic [11:0] CSR_MSCRATCH = 12'h340;
  localparam logic [11:0] CSR_MTVEC    = 12'h305;
  localparam logic [11:0] CSR_MEPC     = 12'h341;
  localparam logic [11:0] CSR_MCAUSE   = 12'h342;
  localparam logic [11:0] CSR_MCYCLE   = 12'hB00;
  localparam logic [11:0] CSR_MINSTRET = 12'hB02;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_r_t;

  typedef struct packed {
    logic [11:0] addr;
    logic [4:0]  zimm;   // Also rs1.
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_csr_t;

  typedef union packed {
    inst_r_t   r;
    inst_csr_t csr;
  } inst_u;

endpackage

`default_nettype wire

// File: hw/exe_pkg.sv
//////////////////////////////////////////////////
// Execute stage bundles and CSR access request.
//////////////////////////////////////////////////
`default_nettype none

package exe_pkg;

  // Stage controller states.
  localparam logic EXE_IDLE = 1'b0;
  localparam logic EXE_BUSY = 1'b1;

  // CSR access kinds as in funct3[1:0].
  localparam logic [1:0] CSR_OP_WRITE = 2'b01;
  localparam logic [1:0] CSR_OP_SET   = 2'b10;
  localparam logic [1:0] CSR_OP_CLEAR = 2'b11;

  typedef struct packed {
    logic [rv_isa_pkg::XLEN-1:0] pc;
    logic [rv_isa_pkg::XLEN-1:0] pc_pred;
    rv_isa_pkg::inst_u           inst;
    logic [rv_isa_pkg::XLEN-1:0] op1;
    logic [rv_isa_pkg::XLEN-1:0] op2;  // rs2 or immediate.
    logic [rv_isa_pkg::XLEN-1:0] op3;  // Branch/jump offset.
    logic [4:0]                  rd;
    logic                        rd_wen;
    logic                        nocmt; // Bubble.
  } exe_req_t;

  typedef struct packed {
    logic [rv_isa_pkg::XLEN-1:0] pc;
    rv_isa_pkg::inst_u           inst;
    logic [4:0]                  rd;
    logic                        rd_wen;
    logic [rv_isa_pkg::XLEN-1:0] rd_wdata;
    logic                        pc_jmp;
    logic [rv_isa_pkg::XLEN-1:0] pc_jmpaddr;
    logic                        nocmt;
  } exe_res_t;

  typedef struct packed {
    logic [11:0]                 addr;
    logic [1:0]                  op;
    logic [rv_isa_pkg::XLEN-1:0] src;
    logic                        wr;
  } csr_req_t;

endpackage

`default_nettype wire

// File: hw/exe_ctrl.sv
//////////////////////////////////////////////////
// Execute stage controller.
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module exe_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic i_decoded_req,
  input  logic i_executed_ack,
  output logic o_decoded_ack,
  output logic o_executed_req,
  output logic o_load,
  output logic o_commit
);

  logic state_q;

  assign o_decoded_ack  = (state_q == exe_pkg::EXE_IDLE);
  assign o_executed_req = (state_q == exe_pkg::EXE_BUSY);

  assign o_load   = i_decoded_req & o_decoded_ack;    // Capture.
  assign o_commit = i_executed_ack & o_executed_req;  // Retire.

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= exe_pkg::EXE_IDLE;
    end else if (o_load) begin
      state_q <= exe_pkg::EXE_BUSY;
    end else if (o_commit) begin
      state_q <= exe_pkg::EXE_IDLE;
    end
  end

endmodule

`default_nettype wire

// File: hw/exe_alu.sv
//////////////////////////////////////////////////
// Integer ALU, branch compare and next pc check.
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module exe_alu (
  input  exe_pkg::exe_req_t            i_req,
  output logic [rv_isa_pkg::XLEN-1:0] o_rd_wdata,
  output logic                        o_pc_jmp,
  output logic [rv_isa_pkg::XLEN-1:0] o_pc_jmpaddr
);

  logic [6:0]                  opcode;
  logic [2:0]                  funct3;
  logic [6:0]                  funct7;
  logic [5:0]                  shamt;
  logic                        sub_sel;
  logic                        br_taken;
  logic [rv_isa_pkg::XLEN-1:0] op1;
  logic [rv_isa_pkg::XLEN-1:0] op2;
  logic [rv_isa_pkg::XLEN-1:0] alu_res;
  logic [rv_isa_pkg::XLEN-1:0] pc_seq;
  logic [rv_isa_pkg::XLEN-1:0] pc_target;
  logic [rv_isa_pkg::XLEN-1:0] jalr_sum;
  logic [rv_isa_pkg::XLEN-1:0] next_pc;

  assign opcode = i_req.inst.r.opcode;
  assign funct3 = i_req.inst.r.funct3;
  assign funct7 = i_req.inst.r.funct7;
  assign op1    = i_req.op1;
  assign op2    = i_req.op2;
  assign shamt  = op2[5:0];

  // SUB exists only in the register form.
  assign sub_sel = (opcode == rv_isa_pkg::OPC_OP) & funct7[5];

  assign pc_seq    = i_req.pc + 64'd4;
  assign pc_target = i_req.pc + i_req.op3;
  assign jalr_sum  = op1 + i_req.op3;

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////
  always_comb begin
    alu_res = '0;
    case (funct3)
      rv_isa_pkg::F3_ADD:  alu_res = sub_sel ? (op1 - op2) : (op1 + op2);
      rv_isa_pkg::F3_SLL:  alu_res = op1 << shamt;
      rv_isa_pkg::F3_SLT:  alu_res = {63'd0, $signed(op1) < $signed(op2)};
      rv_isa_pkg::F3_SLTU: alu_res = {63'd0, op1 < op2};
      rv_isa_pkg::F3_XOR:  alu_res = op1 ^ op2;
      rv_isa_pkg::F3_SR: begin
        if (funct7[5]) begin
          alu_res = $signed(op1) >>> shamt;  // SRA and SRAI.
        end else begin
          alu_res = op1 >> shamt;
        end
      end
      rv_isa_pkg::F3_OR:   alu_res = op1 | op2;
      rv_isa_pkg::F3_AND:  alu_res = op1 & op2;
      default:             alu_res = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Branch compare
  //////////////////////////////////////////////////
  always_comb begin
    case (funct3)
      rv_isa_pkg::F3_BEQ:  br_taken = (op1 == op2);
      rv_isa_pkg::F3_BNE:  br_taken = (op1 != op2);
      rv_isa_pkg::F3_BLT:  br_taken = ($signed(op1) < $signed(op2));
      rv_isa_pkg::F3_BGE:  br_taken = ($signed(op1) >= $signed(op2));
      rv_isa_pkg::F3_BLTU: br_taken = (op1 < op2);
      rv_isa_pkg::F3_BGEU: br_taken = (op1 >= op2);
      default:             br_taken = 1'b0;
    endcase
  end

  // Write-back value and real next pc.
  always_comb begin
    o_rd_wdata = '0;
    next_pc    = pc_seq;
    case (opcode)
      rv_isa_pkg::OPC_OP,
      rv_isa_pkg::OPC_OP_IMM: o_rd_wdata = alu_res;
      rv_isa_pkg::OPC_LUI:    o_rd_wdata = op2;
      rv_isa_pkg::OPC_AUIPC:  o_rd_wdata = i_req.pc + op2;
      rv_isa_pkg::OPC_JAL: begin
        o_rd_wdata = pc_seq;
        next_pc    = pc_target;
      end
      rv_isa_pkg::OPC_JALR: begin
        o_rd_wdata = pc_seq;
        next_pc    = {jalr_sum[rv_isa_pkg::XLEN-1:1], 1'b0};
      end
      rv_isa_pkg::OPC_BRANCH: begin
        if (br_taken) begin
          next_pc = pc_target;
        end
      end
      default: ;
    endcase
  end

  assign o_pc_jmp     = (next_pc != i_req.pc_pred);  // Mispredict.
  assign o_pc_jmpaddr = next_pc;

endmodule

`default_nettype wire

// File: hw/csr_file.sv
//////////////////////////////////////////////////
// Machine CSR registers and read mux.
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module csr_file (
  input  logic                        clk,
  input  logic                        rst,
  input  exe_pkg::csr_req_t           i_csr,
  input  logic                        i_commit,
  input  logic [rv_isa_pkg::XLEN-1:0] i_mcycle,
  input  logic [rv_isa_pkg::XLEN-1:0] i_minstret,
  output logic [rv_isa_pkg::XLEN-1:0] o_rdata
);

  logic [rv_isa_pkg::XLEN-1:0] mscratch_q;
  logic [rv_isa_pkg::XLEN-1:0] mtvec_q;
  logic [rv_isa_pkg::XLEN-1:0] mepc_q;
  logic [rv_isa_pkg::XLEN-1:0] mcause_q;
  logic [rv_isa_pkg::XLEN-1:0] wdata;

  //////////////////////////////////////////////////
  // Read
  //////////////////////////////////////////////////
  always_comb begin
    case (i_csr.addr)
      rv_isa_pkg::CSR_MSCRATCH: o_rdata = mscratch_q;
      rv_isa_pkg::CSR_MTVEC:    o_rdata = mtvec_q;
      rv_isa_pkg::CSR_MEPC:     o_rdata = mepc_q;
      rv_isa_pkg::CSR_MCAUSE:   o_rdata = mcause_q;
      rv_isa_pkg::CSR_MCYCLE:   o_rdata = i_mcycle;
      rv_isa_pkg::CSR_MINSTRET: o_rdata = i_minstret;
      default:                  o_rdata = '0;
    endcase
  end

  // New value from old one.
  always_comb begin
    case (i_csr.op)
      exe_pkg::CSR_OP_WRITE: wdata = i_csr.src;
      exe_pkg::CSR_OP_SET:   wdata = o_rdata | i_csr.src;
      exe_pkg::CSR_OP_CLEAR: wdata = o_rdata & ~i_csr.src;
      default:               wdata = o_rdata;
    endcase
  end

  //////////////////////////////////////////////////
  // Write
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      mscratch_q <= '0;
      mtvec_q    <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end else if (i_commit && i_csr.wr) begin
      case (i_csr.addr)
        rv_isa_pkg::CSR_MSCRATCH: mscratch_q <= wdata;
        rv_isa_pkg::CSR_MTVEC:    mtvec_q    <= wdata;
        rv_isa_pkg::CSR_MEPC:     mepc_q     <= wdata;
        rv_isa_pkg::CSR_MCAUSE:   mcause_q   <= wdata;
        default: ;  // Counters are read-only here.
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/csr_counter.sv
//////////////////////////////////////////////////
// Cycle and retired-instruction counters.
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module csr_counter (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        i_commit,
  input  logic                        i_nocmt,
  output logic [rv_isa_pkg::XLEN-1:0] o_mcycle,
  output logic [rv_isa_pkg::XLEN-1:0] o_minstret
);

  always_ff @(posedge clk) begin
    if (rst) begin
      o_mcycle <= '0;
    end else begin
      o_mcycle <= o_mcycle + 64'd1;
    end
  end

  // Bubbles do not retire.
  always_ff @(posedge clk) begin
    if (rst) begin
      o_minstret <= '0;
    end else if (i_commit && !i_nocmt) begin
      o_minstret <= o_minstret + 64'd1;
    end
  end

endmodule

`default_nettype wire

// File: hw/exe_stage.sv
//////////////////////////////////////////////////
// Execute stage top with bundle capture register.
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module exe_stage (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_decoded_req,
  input  exe_pkg::exe_req_t i_req,
  input  logic              i_executed_ack,
  output logic              o_decoded_ack,
  output logic              o_executed_req,
  output exe_pkg::exe_res_t o_res
);

  exe_pkg::exe_req_t           req_q;
  exe_pkg::csr_req_t           csr_req;
  exe_pkg::exe_res_t           res;
  logic                        load;
  logic                        commit;
  logic                        is_sys;
  logic                        is_csr;
  logic                        is_imm;
  logic [2:0]                  f3;
  logic                        alu_jmp;
  logic [rv_isa_pkg::XLEN-1:0] alu_wdata;
  logic [rv_isa_pkg::XLEN-1:0] alu_jmpaddr;
  logic [rv_isa_pkg::XLEN-1:0] csr_rdata;
  logic [rv_isa_pkg::XLEN-1:0] mcycle;
  logic [rv_isa_pkg::XLEN-1:0] minstret;
  logic                        held_q;
  logic [rv_isa_pkg::XLEN-1:0] csr_rdata_q;
  logic [rv_isa_pkg::XLEN-1:0] csr_val;

  exe_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .i_decoded_req  (i_decoded_req),
    .i_executed_ack (i_executed_ack),
    .o_decoded_ack  (o_decoded_ack),
    .o_executed_req (o_executed_req),
    .o_load         (load),
    .o_commit       (commit)
  );

  always_ff @(posedge clk) begin
    if (load) begin
      req_q <= i_req;
    end
  end

  //////////////////////////////////////////////////
  // CSR access
  //////////////////////////////////////////////////
  assign f3     = req_q.inst.csr.funct3;
  assign is_sys = (req_q.inst.csr.opcode == rv_isa_pkg::OPC_SYSTEM);
  assign is_imm = (f3 == rv_isa_pkg::F3_CSRRWI) | (f3 == rv_isa_pkg::F3_CSRRSI) |
                  (f3 == rv_isa_pkg::F3_CSRRCI);
  assign is_csr = is_sys & (is_imm | (f3 == rv_isa_pkg::F3_CSRRW) |
                  (f3 == rv_isa_pkg::F3_CSRRS) | (f3 == rv_isa_pkg::F3_CSRRC));

  always_comb begin
    csr_req.addr = req_q.inst.csr.addr;
    csr_req.op   = f3[1:0];
    csr_req.src  = is_imm ? {59'd0, req_q.inst.csr.zimm} : req_q.op1;
    // Set/clear with a zero source must not write.
    csr_req.wr   = is_csr & ((f3 == rv_isa_pkg::F3_CSRRW) | (f3 == rv_isa_pkg::F3_CSRRWI) |
                   (req_q.inst.csr.zimm != 5'd0));
  end

  exe_alu u_alu (
    .i_req        (req_q),
    .o_rd_wdata   (alu_wdata),
    .o_pc_jmp     (alu_jmp),
    .o_pc_jmpaddr (alu_jmpaddr)
  );

  csr_file u_csr (
    .clk        (clk),
    .rst        (rst),
    .i_csr      (csr_req),
    .i_commit   (commit),
    .i_mcycle   (mcycle),
    .i_minstret (minstret),
    .o_rdata    (csr_rdata)
  );

  csr_counter u_cnt (
    .clk        (clk),
    .rst        (rst),
    .i_commit   (commit),
    .i_nocmt    (req_q.nocmt),
    .o_mcycle   (mcycle),
    .o_minstret (minstret)
  );

  // Freeze the CSR read value while the result is stalled.
  always_ff @(posedge clk) begin
    if (rst) begin
      held_q <= 1'b0;
    end else begin
      held_q <= o_executed_req & ~commit;
    end
  end

  always_ff @(posedge clk) begin
    if (!held_q) begin
      csr_rdata_q <= csr_rdata;
    end
  end

  assign csr_val = held_q ? csr_rdata_q : csr_rdata;

  always_comb begin
    res.pc         = req_q.pc;
    res.inst       = req_q.inst;
    res.rd         = req_q.rd;
    res.rd_wen     = req_q.rd_wen;
    res.rd_wdata   = is_sys ? csr_val : alu_wdata;
    res.pc_jmp     = is_sys ? 1'b0 : alu_jmp;
    res.pc_jmpaddr = alu_jmpaddr;
    res.nocmt      = req_q.nocmt;
  end

  assign o_res = o_executed_req ? res : '0;  // Zero while idle.

endmodule

`default_nettype wire

// File: dv/exe_stage_tb.sv
//////////////////////////////////////////////////
// Execute stage testbench that replays vectors
// from the data file under random back-pressure.
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module exe_stage_tb;

  localparam int VEC_W   = 13;  // Words per vector.
  localparam int MAX_VEC = 64;
  localparam int TIMEOUT = 20;

  // Vector modes.
  localparam logic [63:0] MODE_FULL     = 64'h0;
  localparam logic [63:0] MODE_MINSTRET = 64'h1;
  localparam logic [63:0] MODE_MCYCLE   = 64'h2;
  localparam logic [63:0] MODE_END      = 64'hff;

  logic              clk;
  logic              rst;
  logic              i_decoded_req;
  logic              i_executed_ack;
  logic              o_decoded_ack;
  logic              o_executed_req;
  exe_pkg::exe_req_t i_req;
  exe_pkg::exe_res_t o_res;

  logic [63:0] vec_mem [0:MAX_VEC*VEC_W-1];
  logic [63:0] retired;      // Commits with nocmt low.
  logic [63:0] last_mcycle;
  int          seed;
  int          nvec;

  exe_stage DUT (
    .clk            (clk),
    .rst            (rst),
    .i_decoded_req  (i_decoded_req),
    .i_req          (i_req),
    .i_executed_ack (i_executed_ack),
    .o_decoded_ack  (o_decoded_ack),
    .o_executed_req (o_executed_req),
    .o_res          (o_res)
  );

  always #5 clk = ~clk;

  task automatic check_value(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
    if (got !== exp) begin
      $display("error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s did not go high within %0d cycles", what, TIMEOUT);
    $display(">>> FAIL");
    $fatal(1, "handshake timeout");
  endtask

  task automatic await_ack();
    int n;
    n = 0;
    while (o_decoded_ack !== 1'b1) begin
      if (n >= TIMEOUT) begin
        report_timeout("o_decoded_ack");
      end else begin
        @(posedge clk);
        #1;
        n++;
      end
    end
  endtask

  task automatic await_result(output int waited);
    waited = 0;
    while (o_executed_req !== 1'b1) begin
      if (waited >= TIMEOUT) begin
        report_timeout("o_executed_req");
      end else begin
        @(posedge clk);
        #1;
        waited++;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // One vector through both handshakes
  //////////////////////////////////////////////////
  task automatic run_vector(input int idx);
    int                base;
    int                delay;
    int                waited;
    logic [63:0]       mode;
    exe_pkg::exe_req_t req;
    exe_pkg::exe_res_t snap;
    base        = idx * VEC_W;
    mode        = vec_mem[base];
    req.pc      = vec_mem[base+2];
    req.pc_pred = vec_mem[base+3];
    req.inst    = vec_mem[base+4][31:0];
    req.op1     = vec_mem[base+5];
    req.op2     = vec_mem[base+6];
    req.op3     = vec_mem[base+7];
    req.rd      = vec_mem[base+4][11:7];
    req.rd_wen  = vec_mem[base+8][0];
    req.nocmt   = vec_mem[base+9][0];
    if (vec_mem[base+1] != 64'd0) begin
      delay = int'(vec_mem[base+1]);  // Fixed stall from the file.
    end else begin
      delay = {$random(seed)} % 4;
    end

    await_ack();
    i_req         = req;
    i_decoded_req = 1'b1;
    @(posedge clk);
    #1;
    i_decoded_req = 1'b0;
    await_result(waited);
    check_value("o_executed_req latency", 256'(waited), 256'(0));
    check_value("o_decoded_ack", 256'(o_decoded_ack), 256'(0));
    check_value("o_res.pc", 256'(o_res.pc), 256'(req.pc));
    check_value("o_res.inst", 256'(o_res.inst), 256'(req.inst));
    check_value("o_res.rd", 256'(o_res.rd), 256'(req.rd));
    check_value("o_res.rd_wen", 256'(o_res.rd_wen), 256'(req.rd_wen));
    check_value("o_res.nocmt", 256'(o_res.nocmt), 256'(req.nocmt));
    check_value("o_res.pc_jmp", 256'(o_res.pc_jmp), 256'(vec_mem[base+11][0]));
    check_value("o_res.pc_jmpaddr", 256'(o_res.pc_jmpaddr), 256'(vec_mem[base+12]));
    case (mode)
      MODE_FULL: check_value("o_res.rd_wdata", 256'(o_res.rd_wdata), 256'(vec_mem[base+10]));
      MODE_MINSTRET: check_value("o_res.rd_wdata", 256'(o_res.rd_wdata), 256'(retired));
      MODE_MCYCLE: begin
        check_value("mcycle increase", 256'(o_res.rd_wdata > last_mcycle), 256'(1));
        last_mcycle = o_res.rd_wdata;
      end
      default: ;  // Branch vectors have no write-back.
    endcase

    // Stalled result must hold.
    snap = o_res;
    repeat (delay) begin
      @(posedge clk);
      #1;
      check_value("o_res", 256'(o_res), 256'(snap));
      check_value("o_decoded_ack", 256'(o_decoded_ack), 256'(0));
      check_value("o_executed_req", 256'(o_executed_req), 256'(1));
    end

    i_executed_ack = 1'b1;
    @(posedge clk);
    #1;
    i_executed_ack = 1'b0;
    if (!req.nocmt) begin
      retired = retired + 64'd1;
    end
    check_value("o_executed_req", 256'(o_executed_req), 256'(0));
    check_value("o_decoded_ack", 256'(o_decoded_ack), 256'(1));
    check_value("o_res", 256'(o_res), 256'(0));  // Gated while idle.
  endtask

  initial begin
    seed           = 39;
    clk            = 1'b0;
    rst            = 1'b1;
    i_decoded_req  = 1'b0;
    i_executed_ack = 1'b0;
    i_req          = '0;
    retired        = 64'd0;
    last_mcycle    = 64'd0;
    nvec           = 0;
    $readmemh("dv/exe_testdata.hex", vec_mem);

    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    check_value("o_decoded_ack", 256'(o_decoded_ack), 256'(1));
    check_value("o_executed_req", 256'(o_executed_req), 256'(0));
    check_value("o_res", 256'(o_res), 256'(0));

    while (nvec < MAX_VEC && vec_mem[nvec*VEC_W] != MODE_END) begin
      run_vector(nvec);
      nvec++;
    end

    $display("%0d vectors applied", nvec);
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
hw/rv_isa_pkg.sv
hw/exe_pkg.sv
hw/exe_ctrl.sv
hw/exe_alu.sv
hw/csr_file.sv
hw/csr_counter.sv
hw/exe_stage.sv
dv/exe_stage_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
  -f vlog.f --top-module exe_stage_tb -o sim_exe_stage
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_exe_stage 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qxF ">>> PASS" <<< "$output"; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi

// File: dv/exe_testdata.hex
// mode hold pc pc_pred inst op1 op2 op3 rd_wen nocmt rd_wdata pc_jmp pc_jmpaddr
// mode 0 full, 1 minstret read, 2 mcycle read, 3 branch without write-back, ff ends the list
0 0 1000 1004 00c58533 fffffffffffffff0 3 0 1 0 fffffffffffffff3 0 1004
0 0 1000 1004 40c58533 fffffffffffffff0 3 0 1 0 ffffffffffffffed 0 1004
0 0 1000 1004 00c59533 fffffffffffffff0 3 0 1 0 ffffffffffffff80 0 1004
0 0 1000 1004 00c5a533 fffffffffffffff0 3 0 1 0 1 0 1004
0 0 1000 1004 00c5b533 fffffffffffffff0 3 0 1 0 0 0 1004
0 0 1000 1004 00c5c533 fffffffffffffff0 3 0 1 0 fffffffffffffff3 0 1004
0 0 1000 1004 00c5d533 fffffffffffffff0 3 0 1 0 1ffffffffffffffe 0 1004
0 0 1000 1004 40c5d533 fffffffffffffff0 3 0 1 0 fffffffffffffffe 0 1004
0 0 1000 1004 00c5e533 fffffffffffffff0 3 0 1 0 fffffffffffffff3 0 1004
0 0 1000 1004 00c5f533 fffffffffffffff0 3 0 1 0 0 0 1004
0 0 1000 1004 fff58513 10 ffffffffffffffff 0 1 0 f 0 1004
0 0 1000 1004 4045d513 8000000000000000 404 0 1 0 f800000000000000 0 1004
0 0 1000 1004 00359513 1 3 0 1 0 8 0 1004
0 0 1000 1004 ffb5a513 fffffffffffffffa fffffffffffffffb 0 1 0 1 0 1004
0 0 1000 1004 12345537 0 12345000 0 1 0 12345000 0 1004
0 0 1000 1004 80000537 0 ffffffff80000000 0 1 0 ffffffff80000000 0 1004
0 0 1000 1004 00001517 0 1000 0 1 0 2000 0 1004
0 0 2000 2010 0100056f 0 0 10 1 0 2004 0 2010
0 0 2000 2004 0100056f 0 0 10 1 0 2004 1 2010
0 0 4000 4004 00858567 3001 0 8 1 0 4004 1 3008
0 0 4000 3008 00858567 3001 0 8 1 0 4004 0 3008
3 0 5000 5008 00c58463 7 7 8 0 0 0 0 5008
3 0 5000 5008 00c58463 7 8 8 0 0 0 1 5004
3 0 5000 5004 00c59463 7 8 8 0 0 0 1 5008
3 0 5000 5008 00c5c463 ffffffffffffffff 1 8 0 0 0 0 5008
3 0 5000 5004 00c5d463 ffffffffffffffff 1 8 0 0 0 0 5004
3 0 5000 5008 00c5e463 ffffffffffffffff 1 8 0 0 0 1 5004
3 0 5000 5004 00c5f463 ffffffffffffffff 1 8 0 0 0 1 5008
0 6 6000 6004 34059573 f0f 0 0 1 0 0 0 6004
0 0 6000 6004 3405a573 f000 0 0 1 0 f0f 0 6004
0 5 6000 6004 3405b573 f 0 0 1 0 ff0f 0 6004
0 0 6000 6004 3402d573 ffff 0 0 1 0 ff00 0 6004
0 0 6000 6004 34002573 0 0 0 1 0 5 0 6004
0 4 6000 6004 30559573 80000100 0 0 1 0 0 0 6004
0 0 6000 6004 3051e573 ffff 0 0 1 0 80000100 0 6004
0 0 6000 6004 3050f573 ffff 0 0 1 0 80000103 0 6004
0 0 6000 6004 30502573 0 0 0 1 0 80000102 0 6004
0 0 7000 7004 00158513 1 1 0 0 1 2 0 7004
1 0 7000 7004 b0202573 0 0 0 1 0 0 0 7004
2 0 7000 7004 b0002573 0 0 0 1 0 0 0 7004
2 0 7000 7004 b0002573 0 0 0 1 0 0 0 7004
ff
